// ==== lsu_agu_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_agu_stage (
    input  logic              clk,
    input  logic              rst,
    input  lsu_pkg::lsu_req_t req_i,
    output lsu_pkg::lsu_s1_t  s1_o
);

    lsu_pkg::xlen_t        addr;
    lsu_pkg::byte_offset_t offset;
    lsu_pkg::byte_mask_t   mask;
    logic                  misalign;
    lsu_pkg::lsu_s1_t      s1_d;
    lsu_pkg::lsu_s1_t      s1_q;
    logic                  valid_q;

    assign addr   = req_i.base + req_i.imm;
    assign offset = addr[1:0];

    always_comb begin
        case (req_i.size)
            lsu_pkg::SIZE_HALF: misalign = offset[0];
            lsu_pkg::SIZE_WORD: misalign = |offset;
            default:            misalign = 1'b0;
        endcase
    end

    // lanes start at the byte offset
    always_comb begin
        case (req_i.size)
            lsu_pkg::SIZE_BYTE: mask = lsu_pkg::byte_mask_t'(4'b0001) << offset;
            lsu_pkg::SIZE_HALF: mask = lsu_pkg::byte_mask_t'(4'b0011) << offset;
            lsu_pkg::SIZE_WORD: mask = {(`LSU_XLEN/8){1'b1}};
            default:            mask = '0;
        endcase
    end

    always_comb begin
        s1_d.valid    = req_i.valid;
        s1_d.is_store = req_i.is_store;
        s1_d.uext     = req_i.uext;
        s1_d.size     = req_i.size;
        s1_d.tag      = req_i.tag;
        s1_d.addr     = addr;
        s1_d.mask     = mask;
        s1_d.misalign = misalign;
        s1_d.wdata    = req_i.wdata;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_q <= s1_d;
    end

    always_comb begin
        s1_o       = s1_q;
        s1_o.valid = valid_q;
    end

    // size 3 has no meaning on the request port
    a_no_rsvd_size: assert property (@(posedge clk) disable iff (rst)
        req_i.valid |-> req_i.size != lsu_pkg::mem_size_e'(2'd3))
        else $error("valid request with reserved size");

endmodule

`default_nettype wire

// ==== lsu_align_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_align_stage (
    input  logic               clk,
    input  logic               rst,
    input  lsu_pkg::lsu_s2_t   s2_i,
    output lsu_pkg::lsu_resp_t resp_o
);

    logic [2*`LSU_XLEN-1:0] rdata_dbl;
    logic [4:0]             shamt;
    lsu_pkg::xlen_t         rot;
    lsu_pkg::xlen_t         ext;
    lsu_pkg::exc_code_e     exc;
    lsu_pkg::lsu_resp_t     resp_d;
    lsu_pkg::lsu_resp_t     resp_q;
    logic                   valid_q;

    // rotate so the addressed byte lands in lane 0
    assign shamt     = {s2_i.offset, 3'b000};
    assign rdata_dbl = {s2_i.rdata, s2_i.rdata} >> shamt;
    assign rot       = rdata_dbl[`LSU_XLEN-1:0];

    always_comb begin
        case (s2_i.size)
            lsu_pkg::SIZE_BYTE: ext = {{(`LSU_XLEN-8){~s2_i.uext & rot[7]}}, rot[7:0]};
            lsu_pkg::SIZE_HALF: ext = {{(`LSU_XLEN-16){~s2_i.uext & rot[15]}}, rot[15:0]};
            lsu_pkg::SIZE_WORD: ext = rot;
            default:            ext = '0;
        endcase
    end

    always_comb begin
        if (!s2_i.misalign) begin
            exc = lsu_pkg::EXC_NONE;
        end else if (s2_i.is_store) begin
            exc = lsu_pkg::EXC_STORE_MISALIGN;
        end else begin
            exc = lsu_pkg::EXC_LOAD_MISALIGN;
        end
    end

    always_comb begin
        resp_d.valid    = s2_i.valid;
        resp_d.tag      = s2_i.tag;
        resp_d.is_store = s2_i.is_store;
        resp_d.exc      = exc;
        // stores and faulting loads return no data
        resp_d.data     = (s2_i.is_store | s2_i.misalign) ? '0 : ext;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= s2_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        resp_q <= resp_d;
    end

    always_comb begin
        resp_o       = resp_q;
        resp_o.valid = valid_q;
    end

    a_resp_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(resp_o.valid))
        else $error("response valid is unknown");

endmodule

`default_nettype wire

// ==== lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data path width in bits
`define LSU_XLEN 32

// data memory size in words
`define LSU_MEM_WORDS 64

// word index width, log2 of LSU_MEM_WORDS
`define LSU_MEM_AW 6

// operation tag carried to writeback
`define LSU_TAG_WIDTH 6

`endif

// ==== lsu_mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  lsu_pkg::lsu_s1_t s1_i,
    output lsu_pkg::lsu_s2_t s2_o
);

    lsu_pkg::xlen_t        mem [`LSU_MEM_WORDS];
    logic [`LSU_MEM_AW-1:0] widx;
    lsu_pkg::byte_offset_t offset;
    logic                  wr_en;
    lsu_pkg::xlen_t        wdata_sh;
    lsu_pkg::lsu_s2_t      s2_d;
    lsu_pkg::lsu_s2_t      s2_q;
    logic                  valid_q;

    // upper address bits dropped, so addresses wrap
    assign widx   = s1_i.addr[`LSU_MEM_AW+1:2];
    assign offset = s1_i.addr[1:0];

    // misaligned stores leave memory alone
    assign wr_en = s1_i.valid & s1_i.is_store & ~s1_i.misalign;

    // low store bytes moved up to their lane
    assign wdata_sh = s1_i.wdata << {offset, 3'b000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < `LSU_XLEN/8; b++) begin
                if (s1_i.mask[b]) begin
                    mem[widx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        s2_d.valid    = s1_i.valid;
        s2_d.is_store = s1_i.is_store;
        s2_d.uext     = s1_i.uext;
        s2_d.size     = s1_i.size;
        s2_d.tag      = s1_i.tag;
        s2_d.offset   = offset;
        s2_d.misalign = s1_i.misalign;
        s2_d.rdata    = mem[widx];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= s1_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_q <= s2_d;
    end

    always_comb begin
        s2_o       = s2_q;
        s2_o.valid = valid_q;
    end

    // the addressed word survives any cycle without an aligned valid store
    a_no_stray_write: assert property (@(posedge clk) disable iff (rst)
        !(s1_i.valid && s1_i.is_store && !s1_i.misalign)
        |=> mem[$past(widx)] == $past(mem[widx]))
        else $error("memory changed without an aligned store");

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] xlen_t;
    typedef logic [`LSU_TAG_WIDTH-1:0] tag_t;
    typedef logic [`LSU_XLEN/8-1:0] byte_mask_t;
    typedef logic [1:0] byte_offset_t;

    // value 3 is reserved
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        EXC_NONE           = 2'd0,
        EXC_LOAD_MISALIGN  = 2'd1,
        EXC_STORE_MISALIGN = 2'd2
    } exc_code_e;

    typedef struct packed {
        logic      valid;
        logic      is_store;
        logic      uext;
        mem_size_e size;
        tag_t      tag;
        xlen_t     base;
        xlen_t     imm;
        xlen_t     wdata;
    } lsu_req_t;

    typedef struct packed {
        logic       valid;
        logic       is_store;
        logic       uext;
        mem_size_e  size;
        tag_t       tag;
        xlen_t      addr;
        byte_mask_t mask;
        logic       misalign;
        xlen_t      wdata;
    } lsu_s1_t;

    typedef struct packed {
        logic         valid;
        logic         is_store;
        logic         uext;
        mem_size_e    size;
        tag_t         tag;
        byte_offset_t offset;
        logic         misalign;
        xlen_t        rdata;
    } lsu_s2_t;

    typedef struct packed {
        logic      valid;
        tag_t      tag;
        logic      is_store;
        exc_code_e exc;
        xlen_t     data;
    } lsu_resp_t;

endpackage

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_top (
    input  logic               clk,
    input  logic               rst,
    input  lsu_pkg::lsu_req_t  req_i,
    output lsu_pkg::lsu_resp_t resp_o
);

    // stage 1 to stage 2
    lsu_pkg::lsu_s1_t s1;

    // stage 2 to stage 3
    lsu_pkg::lsu_s2_t s2;

    // address, alignment check and byte mask
    lsu_agu_stage u_agu (
        .clk   (clk),
        .rst   (rst),
        .req_i (req_i),
        .s1_o  (s1)
    );

    // data memory access
    lsu_mem_stage u_mem (
        .clk  (clk),
        .rst  (rst),
        .s1_i (s1),
        .s2_o (s2)
    );

    // load data extraction and writeback response
    lsu_align_stage u_align (
        .clk    (clk),
        .rst    (rst),
        .s2_i   (s2),
        .resp_o (resp_o)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the LSU testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_lsu \
    -Mdir obj_dir -o sim_lsu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_lsu > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== sources.f ====
+incdir+.
lsu_pkg.sv
lsu_agu_stage.sv
lsu_mem_stage.sv
lsu_align_stage.sv
lsu_top.sv
tb_lsu.sv

// ==== tb_lsu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu;

    localparam int CLK_PERIOD = 100;
    localparam int N_DIRECTED = 33;
    localparam int N_RANDOM   = 400;

    typedef struct packed {
        logic [31:0]        due;
        lsu_pkg::tag_t      tag;
        logic               is_store;
        lsu_pkg::exc_code_e exc;
        lsu_pkg::xlen_t     data;
    } expect_t;

    logic               clk;
    logic               rst;
    lsu_pkg::lsu_req_t  req;
    lsu_pkg::lsu_resp_t resp;

    // reference memory with the DUT's word count
    lsu_pkg::xlen_t ref_mem [`LSU_MEM_WORDS];
    expect_t        exp_q [$];
    int unsigned    cyc;
    lsu_pkg::tag_t  next_tag;

    lsu_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .req_i  (req),
        .resp_o (resp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch %s: actual 0x%08h expected 0x%08h",
                                     name, actual, expected));
        end
    endtask

    function automatic int size_bytes(input lsu_pkg::mem_size_e size);
        case (size)
            lsu_pkg::SIZE_BYTE: return 1;
            lsu_pkg::SIZE_HALF: return 2;
            default:            return 4;
        endcase
    endfunction

    // natural alignment means address a multiple of the access size
    function automatic logic misaligned(input lsu_pkg::xlen_t addr,
                                        input lsu_pkg::mem_size_e size);
        return (addr % 32'(size_bytes(size))) != 32'd0;
    endfunction

    task automatic store_model(input lsu_pkg::xlen_t addr, input lsu_pkg::mem_size_e size,
                               input lsu_pkg::xlen_t wdata);
        int nb;
        int off;
        int idx;
        nb  = size_bytes(size);
        off = int'(addr[1:0]);
        idx = int'(addr[`LSU_MEM_AW+1:2]);
        for (int i = 0; i < nb; i++) begin
            ref_mem[idx][(off + i) * 8 +: 8] = wdata[i * 8 +: 8];
        end
    endtask

    function automatic lsu_pkg::xlen_t load_value(input lsu_pkg::xlen_t addr,
                                                  input lsu_pkg::mem_size_e size,
                                                  input logic uext);
        int             nb;
        int             off;
        int             idx;
        lsu_pkg::xlen_t v;
        nb  = size_bytes(size);
        off = int'(addr[1:0]);
        idx = int'(addr[`LSU_MEM_AW+1:2]);
        v   = '0;
        // highest byte first, so byte 0 ends up at the bottom
        for (int i = nb - 1; i >= 0; i--) begin
            v = (v << 8) | 32'(ref_mem[idx][(off + i) * 8 +: 8]);
        end
        if (nb < 4 && !uext && v[nb * 8 - 1]) begin
            v = v | (32'hffff_ffff << (nb * 8));
        end
        return v;
    endfunction

    task automatic issue_op(input logic st, input logic uext, input lsu_pkg::mem_size_e size,
                            input lsu_pkg::xlen_t base, input lsu_pkg::xlen_t imm,
                            input lsu_pkg::xlen_t wdata);
        lsu_pkg::xlen_t addr;
        logic           bad;
        expect_t        e;
        addr = base + imm;
        bad  = misaligned(addr, size);
        @(posedge clk);
        #1;
        req.valid    = 1'b1;
        req.is_store = st;
        req.uext     = uext;
        req.size     = size;
        req.tag      = next_tag;
        req.base     = base;
        req.imm      = imm;
        req.wdata    = wdata;
        // response due three cycles after issue
        e.due        = cyc + 3;
        e.tag        = next_tag;
        e.is_store   = st;
        e.data       = '0;
        if (!bad) begin
            e.exc = lsu_pkg::EXC_NONE;
        end else if (st) begin
            e.exc = lsu_pkg::EXC_STORE_MISALIGN;
        end else begin
            e.exc = lsu_pkg::EXC_LOAD_MISALIGN;
        end
        if (!bad && st) begin
            store_model(addr, size, wdata);
        end else if (!bad) begin
            e.data = load_value(addr, size, uext);
        end
        exp_q.push_back(e);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            req.valid = 1'b0;
        end
    endtask

    // scoreboard sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            if (resp.valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("response arrived with no request outstanding");
                end
                e = exp_q.pop_front();
                check("resp_cycle", cyc, e.due);
                check("resp_o.tag", 32'(resp.tag), 32'(e.tag));
                check("resp_o.is_store", 32'(resp.is_store), 32'(e.is_store));
                check("resp_o.exc", 32'(resp.exc), 32'(e.exc));
                check("resp_o.data", resp.data, e.data);
            end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
                report_failure($sformatf("response for tag %0d never arrived", exp_q[0].tag));
            end
        end
    end

    initial begin
        @(negedge rst);
        #((N_DIRECTED + N_RANDOM + 20) * CLK_PERIOD);
        report_failure("watchdog timeout, the run did not finish in time");
    end

    initial begin
        logic               st;
        logic               ux;
        lsu_pkg::mem_size_e sz;
        lsu_pkg::xlen_t     b;
        lsu_pkg::xlen_t     im;
        logic               last_was_store;
        lsu_pkg::xlen_t     last_addr;
        void'($urandom(6));
        clk            = 1'b0;
        rst            = 1'b1;
        req            = '0;
        cyc            = 0;
        next_tag       = '0;
        last_was_store = 1'b0;
        last_addr      = '0;
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // fresh memory reads back as zero
        idle_cycles(3);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0000, 32'h0, '0);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_00f0, 32'hc, '0);
        issue_op(1'b0, 1'b1, lsu_pkg::SIZE_WORD, 32'h1000_0040, 32'h0, '0);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_BYTE, 32'h0000_0020, 32'h3, '0);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_HALF, 32'h0000_0070, 32'he, '0);

        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0010, 32'h0, 32'h8a5c_31f7);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0008, 32'h8, '0);

        // every byte and half offset both signed and unsigned
        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0020, 32'h0, 32'hf17e_8025);
        for (int off = 0; off < 4; off++) begin
            issue_op(1'b0, 1'b0, lsu_pkg::SIZE_BYTE, 32'h0000_0020, 32'(off), '0);
            issue_op(1'b0, 1'b1, lsu_pkg::SIZE_BYTE, 32'h0000_0020, 32'(off), '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_op(1'b0, 1'b0, lsu_pkg::SIZE_HALF, 32'h0000_0020, 32'(off), '0);
            issue_op(1'b0, 1'b1, lsu_pkg::SIZE_HALF, 32'h0000_0020, 32'(off), '0);
        end

        // partial stores keep the other lanes
        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0030, 32'h0, 32'h1122_3344);
        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_BYTE, 32'h0000_0030, 32'h1, 32'haaaa_aa5a);
        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0034, 32'h0, 32'h5566_7788);
        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_HALF, 32'h0000_0034, 32'h2, 32'h0000_c3d2);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0030, 32'h0, '0);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0034, 32'h0, '0);

        // misaligned accesses fault and leave memory alone
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_HALF, 32'h0000_0010, 32'h1, '0);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0010, 32'h2, '0);
        issue_op(1'b0, 1'b1, lsu_pkg::SIZE_WORD, 32'h0000_0010, 32'h3, '0);
        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_HALF, 32'h0000_0020, 32'h1, 32'hffff_ffff);
        issue_op(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0020, 32'h2, 32'hdead_beef);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0020, 32'h0, '0);
        issue_op(1'b0, 1'b0, lsu_pkg::SIZE_WORD, 32'h0000_0010, 32'h0, '0);

        // random back-to-back mix with some loads right behind a store to their word
        for (int n = 0; n < N_RANDOM; n++) begin
            ux = 1'($urandom_range(0, 1));
            if (last_was_store && $urandom_range(0, 3) == 0) begin
                issue_op(1'b0, ux, lsu_pkg::SIZE_WORD, last_addr & 32'hffff_fffc, 32'h0, '0);
                last_was_store = 1'b0;
            end else begin
                st = 1'($urandom_range(0, 1));
                sz = lsu_pkg::mem_size_e'(2'($urandom_range(0, 2)));
                b  = $urandom;
                im = $urandom_range(0, 15);
                issue_op(st, ux, sz, b, im, $urandom);
                last_was_store = st;
                last_addr      = b + im;
            end
        end
        idle_cycles(1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a few quiet cycles catch any stray response
        repeat (5) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
